/* rtl/sched_pkg.sv */
package sched_pkg;

  // Defaults picked up by the top level
  localparam int CORE_COUNT_DEF = 4;
  localparam int SLOT_COUNT_DEF = 8;
  localparam int PORT_COUNT_DEF = 2;

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  typedef logic [1:0] core_id_t;
  // Slots are numbered from 1, so a count of 8 needs the extra bit
  typedef logic [3:0] slot_id_t;
  typedef logic [0:0] port_id_t;

  typedef enum logic [3:0] {
    SLOT_RETURN = 4'd0,
    SLOT_INIT   = 4'd3
  } msg_type_e;

  typedef enum logic [1:0] {
    IDLE,
    READY,
    BUSY
  } port_state_e;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } rx_word_t;

  typedef struct packed {
    core_id_t core;
    slot_id_t slot;
  } desc_t;

  typedef struct packed {
    msg_type_e   msg_type;
    logic [11:0] spare;
    slot_id_t    slot;
    logic [15:0] low;
  } ctrl_msg_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [2:0]  addr;
    logic [31:0] wr_data;
  } host_cmd_t;

endpackage

/* rtl/ctrl_msg_decoder.sv */
`timescale 1ns/1ps

module ctrl_msg_decoder #(
  parameter int CORE_COUNT = 4
) (
  input  logic                   clk,
  input  logic                   rst_r,
  input  sched_pkg::ctrl_msg_t   ctrl_msg,
  input  sched_pkg::core_id_t    ctrl_src,
  input  logic                   ctrl_valid,
  output logic                   ctrl_ready,
  output logic [CORE_COUNT-1:0]  init_strobe,
  output logic [CORE_COUNT-1:0]  return_strobe,
  output sched_pkg::slot_id_t    slot
);

  // Pools take one message per clock, so nothing ever stalls the source
  assign ctrl_ready = 1'b1;

  // Count for init, slot number for return
  always_ff @(posedge clk) begin
    slot <= ctrl_msg.slot;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_strobe   <= '0;
      return_strobe <= '0;
    end else begin
      init_strobe   <= '0;
      return_strobe <= '0;
      if (ctrl_valid && (int'(ctrl_src) < CORE_COUNT)) begin
        case (ctrl_msg.msg_type)
          sched_pkg::SLOT_INIT:   init_strobe[ctrl_src]   <= 1'b1;
          sched_pkg::SLOT_RETURN: return_strobe[ctrl_src] <= 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

/* rtl/slot_pool.sv */
`timescale 1ns/1ps

module slot_pool #(
  parameter int SLOT_COUNT = 8
) (
  input  logic                clk,
  input  logic                rst_r,
  input  logic                init_strobe,
  input  logic                return_strobe,
  input  sched_pkg::slot_id_t slot,
  input  logic                pop,
  output sched_pkg::slot_id_t head,
  output sched_pkg::slot_id_t count,
  output logic                overflow
);

  localparam int PTR_W = (SLOT_COUNT > 1) ? $clog2(SLOT_COUNT) : 1;

  sched_pkg::slot_id_t mem [SLOT_COUNT];
  logic [PTR_W-1:0]    rd_ptr;
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    wr_ptr_1;
  logic [PTR_W-1:0]    wr_ptr_2;
  sched_pkg::slot_id_t fill_val;
  sched_pkg::slot_id_t fill_end;
  logic                filling;
  logic                fill_push;
  logic                ret_push;
  logic                do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(SLOT_COUNT - 1)) ? '0 : p + 1'b1;
  endfunction

  assign fill_push = filling && !init_strobe && (int'(count) < SLOT_COUNT);
  assign do_pop    = pop && !init_strobe && (count != '0);
  // Fill entry goes first when both land on the same clock
  assign ret_push  = return_strobe && !init_strobe &&
                     ((int'(count) + int'(fill_push)) < SLOT_COUNT);
  assign overflow  = return_strobe && !init_strobe && !ret_push;
  assign wr_ptr_1  = ptr_inc(wr_ptr);
  assign wr_ptr_2  = ptr_inc(wr_ptr_1);
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (fill_push) mem[wr_ptr] <= fill_val;
    if (ret_push) mem[fill_push ? wr_ptr_1 : wr_ptr] <= slot;
  end

  always_ff @(posedge clk) begin
    if (init_strobe) begin
      fill_val <= sched_pkg::slot_id_t'(1);
      fill_end <= (int'(slot) > SLOT_COUNT) ? sched_pkg::slot_id_t'(SLOT_COUNT) : slot;
    end else if (fill_push) begin
      fill_val <= fill_val + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      filling <= 1'b0;
    end else if (init_strobe) begin
      // Drop whatever was queued and start loading 1..n
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      filling <= (slot != '0);
    end else begin
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      if (fill_push && ret_push) begin
        wr_ptr <= wr_ptr_2;
      end else if (fill_push || ret_push) begin
        wr_ptr <= wr_ptr_1;
      end
      count <= count + fill_push + ret_push - do_pop;
      if (fill_push && (fill_val == fill_end)) filling <= 1'b0;
    end
  end

endmodule

/* rtl/core_selector.sv */
`timescale 1ns/1ps

module core_selector #(
  parameter int CORE_COUNT = 4,
  parameter int PORT_COUNT = 2
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::slot_id_t   counts [CORE_COUNT],
  input  sched_pkg::slot_id_t   heads [CORE_COUNT],
  input  logic [CORE_COUNT-1:0] eligible,
  input  logic [PORT_COUNT-1:0] port_req,
  output logic [CORE_COUNT-1:0] pop,
  output logic [PORT_COUNT-1:0] grant,
  output sched_pkg::desc_t      grant_desc
);

  localparam int PW = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;

  logic [PW-1:0]       rr_ptr;
  logic [PW-1:0]       rr_next;
  sched_pkg::core_id_t best_core;
  sched_pkg::slot_id_t best_count;
  logic                core_found;

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best_core  = '0;
    best_count = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (eligible[c] && (counts[c] > best_count)) begin
        best_core  = sched_pkg::core_id_t'(c);
        best_count = counts[c];
      end
    end
  end

  assign core_found = (best_count != '0);

  always_comb begin
    int p;
    grant   = '0;
    rr_next = rr_ptr;
    for (int i = 0; i < PORT_COUNT; i++) begin
      p = (int'(rr_ptr) + i) % PORT_COUNT;
      if (core_found && port_req[p] && (grant == '0)) begin
        grant[p] = 1'b1;
        rr_next  = (p == PORT_COUNT - 1) ? '0 : PW'(p + 1);
      end
    end
  end

  always_comb begin
    pop = '0;
    if (grant != '0) pop[best_core] = 1'b1;
    grant_desc.core = best_core;
    grant_desc.slot = heads[best_core];
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rr_ptr <= '0;
    end else if (grant != '0) begin
      rr_ptr <= rr_next;
    end
  end

endmodule

/* rtl/port_dispatcher.sv */
`timescale 1ns/1ps

module port_dispatcher #(
  parameter int PORT_INDEX = 0
) (
  input  logic                clk,
  input  logic                rst_r,
  input  logic                enabled,
  input  logic                grant,
  input  sched_pkg::desc_t    grant_desc,
  output logic                desc_req,
  input  sched_pkg::rx_word_t rx,
  input  logic                rx_valid,
  output logic                rx_ready,
  output sched_pkg::rx_word_t out_word,
  output sched_pkg::desc_t    out_desc,
  output sched_pkg::port_id_t out_port,
  output logic                out_valid,
  input  logic                out_ready
);

  sched_pkg::port_state_e state;
  sched_pkg::desc_t       desc_r;
  logic                   pass;
  logic                   fire;

  // A disabled port holds its place and takes no slots
  assign desc_req = (state == sched_pkg::IDLE) && enabled;
  assign pass     = (state != sched_pkg::IDLE) && enabled;
  assign fire     = rx_valid && out_ready && pass;

  assign out_valid = rx_valid && pass;
  assign rx_ready  = out_ready && pass;
  assign out_word  = rx;
  assign out_desc  = desc_r;
  assign out_port  = sched_pkg::port_id_t'(PORT_INDEX);

  // Descriptor stays until the last word of the packet is gone
  always_ff @(posedge clk) begin
    if (grant && desc_req) begin
      desc_r <= grant_desc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= sched_pkg::IDLE;
    end else begin
      case (state)
        sched_pkg::IDLE: begin
          if (grant && desc_req) state <= sched_pkg::READY;
        end
        sched_pkg::READY: begin
          if (fire) begin
            if (rx.last) begin
              state <= sched_pkg::IDLE;
            end else begin
              state <= sched_pkg::BUSY;
            end
          end
        end
        sched_pkg::BUSY: begin
          if (fire && rx.last) state <= sched_pkg::IDLE;
        end
        default: begin
          state <= sched_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

/* rtl/host_regs.sv */
`timescale 1ns/1ps

module host_regs #(
  parameter int CORE_COUNT = 4,
  parameter int PORT_COUNT = 2
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::host_cmd_t  host_cmd,
  input  sched_pkg::slot_id_t   counts [CORE_COUNT],
  input  logic [CORE_COUNT-1:0] overflow,
  output logic [CORE_COUNT-1:0] eligible_mask,
  output logic [PORT_COUNT-1:0] port_enable,
  output logic [31:0]           host_rd_data
);

  sched_pkg::host_cmd_t  cmd_r;
  logic [CORE_COUNT-1:0] incoming;
  logic [CORE_COUNT-1:0] enabled;
  logic                  err_flag;
  logic                  wr_en;
  logic [31:0]           rd_value;
  sched_pkg::core_id_t   core_sel;

  assign wr_en         = cmd_r.valid && cmd_r.write;
  assign core_sel      = sched_pkg::core_id_t'(cmd_r.wr_data);
  assign eligible_mask = incoming & enabled;

  always_comb begin
    case (cmd_r.addr)
      3'd0: rd_value = 32'(incoming);
      3'd1: rd_value = 32'(enabled);
      3'd2: rd_value = (int'(core_sel) < CORE_COUNT) ? 32'(counts[core_sel]) : 32'd0;
      3'd3: rd_value = 32'(err_flag);
      3'd5: rd_value = 32'(port_enable);
      default: rd_value = 32'hFEFEFEFE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      cmd_r        <= '0;
      incoming     <= '0;
      enabled      <= '0;
      port_enable  <= '0;
      err_flag     <= 1'b0;
      host_rd_data <= '0;
    end else begin
      cmd_r <= host_cmd;
      if (wr_en) begin
        case (cmd_r.addr)
          // Only enabled cores can take traffic
          3'd0: incoming <= cmd_r.wr_data[CORE_COUNT-1:0] & enabled;
          3'd1: begin
            enabled  <= cmd_r.wr_data[CORE_COUNT-1:0];
            incoming <= incoming & cmd_r.wr_data[CORE_COUNT-1:0];
          end
          3'd5: port_enable <= cmd_r.wr_data[PORT_COUNT-1:0];
          default: ;
        endcase
      end
      // A new overflow wins over a clear on the same clock
      err_flag <= ((wr_en && (cmd_r.addr == 3'd3)) ? 1'b0 : err_flag) | (|overflow);
      if (cmd_r.valid && !cmd_r.write) host_rd_data <= rd_value;
    end
  end

endmodule

/* rtl/rx_scheduler.sv */
`timescale 1ns/1ps

module rx_scheduler #(
  parameter int CORE_COUNT = sched_pkg::CORE_COUNT_DEF,
  parameter int SLOT_COUNT = sched_pkg::SLOT_COUNT_DEF,
  parameter int PORT_COUNT = sched_pkg::PORT_COUNT_DEF
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  sched_pkg::rx_word_t   rx [PORT_COUNT],
  input  logic [PORT_COUNT-1:0] rx_valid,
  output logic [PORT_COUNT-1:0] rx_ready,
  output sched_pkg::rx_word_t   core_out [PORT_COUNT],
  output sched_pkg::desc_t      out_desc [PORT_COUNT],
  output sched_pkg::port_id_t   out_port [PORT_COUNT],
  output logic [PORT_COUNT-1:0] out_valid,
  input  logic [PORT_COUNT-1:0] out_ready,
  input  sched_pkg::ctrl_msg_t  ctrl_in,
  input  sched_pkg::core_id_t   ctrl_src,
  input  logic                  ctrl_valid,
  output logic                  ctrl_ready,
  input  sched_pkg::host_cmd_t  host_cmd,
  output logic [31:0]           host_rd_data
);

  logic [CORE_COUNT-1:0] init_strobe;
  logic [CORE_COUNT-1:0] return_strobe;
  sched_pkg::slot_id_t   dec_slot;
  logic [CORE_COUNT-1:0] pool_pop;
  logic [CORE_COUNT-1:0] pool_overflow;
  sched_pkg::slot_id_t   pool_head [CORE_COUNT];
  sched_pkg::slot_id_t   pool_count [CORE_COUNT];
  logic [CORE_COUNT-1:0] eligible_mask;
  logic [PORT_COUNT-1:0] port_enable;
  logic [PORT_COUNT-1:0] desc_req;
  logic [PORT_COUNT-1:0] grant;
  sched_pkg::desc_t      grant_desc;

  ctrl_msg_decoder #(
    .CORE_COUNT(CORE_COUNT)
  ) decoder_i (
    .clk          (clk),
    .rst_r        (rst_r),
    .ctrl_msg     (ctrl_in),
    .ctrl_src     (ctrl_src),
    .ctrl_valid   (ctrl_valid),
    .ctrl_ready   (ctrl_ready),
    .init_strobe  (init_strobe),
    .return_strobe(return_strobe),
    .slot         (dec_slot)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    slot_pool #(
      .SLOT_COUNT(SLOT_COUNT)
    ) pool_i (
      .clk          (clk),
      .rst_r        (rst_r),
      .init_strobe  (init_strobe[c]),
      .return_strobe(return_strobe[c]),
      .slot         (dec_slot),
      .pop          (pool_pop[c]),
      .head         (pool_head[c]),
      .count        (pool_count[c]),
      .overflow     (pool_overflow[c])
    );
  end

  core_selector #(
    .CORE_COUNT(CORE_COUNT),
    .PORT_COUNT(PORT_COUNT)
  ) selector_i (
    .clk       (clk),
    .rst_r     (rst_r),
    .counts    (pool_count),
    .heads     (pool_head),
    .eligible  (eligible_mask),
    .port_req  (desc_req),
    .pop       (pool_pop),
    .grant     (grant),
    .grant_desc(grant_desc)
  );

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    port_dispatcher #(
      .PORT_INDEX(p)
    ) dispatcher_i (
      .clk       (clk),
      .rst_r     (rst_r),
      .enabled   (port_enable[p]),
      .grant     (grant[p]),
      .grant_desc(grant_desc),
      .desc_req  (desc_req[p]),
      .rx        (rx[p]),
      .rx_valid  (rx_valid[p]),
      .rx_ready  (rx_ready[p]),
      .out_word  (core_out[p]),
      .out_desc  (out_desc[p]),
      .out_port  (out_port[p]),
      .out_valid (out_valid[p]),
      .out_ready (out_ready[p])
    );
  end

  host_regs #(
    .CORE_COUNT(CORE_COUNT),
    .PORT_COUNT(PORT_COUNT)
  ) host_regs_i (
    .clk          (clk),
    .rst_r        (rst_r),
    .host_cmd     (host_cmd),
    .counts       (pool_count),
    .overflow     (pool_overflow),
    .eligible_mask(eligible_mask),
    .port_enable  (port_enable),
    .host_rd_data (host_rd_data)
  );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_r
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_r = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_r <= 1'b0;
  end

endmodule

/* sim/rx_scheduler_tb.sv */
`timescale 1ns/1ps

module rx_scheduler_tb;

  localparam int CORES     = sched_pkg::CORE_COUNT_DEF;
  localparam int SLOTS     = sched_pkg::SLOT_COUNT_DEF;
  localparam int PORTS     = sched_pkg::PORT_COUNT_DEF;
  localparam int PERIOD_NS = 40;
  localparam int NUM_TESTS = 6;
  localparam int MAX_LEN   = 8;
  localparam int MARGIN    = 64;

  logic                 clk;
  logic                 rst_r;
  sched_pkg::rx_word_t  rx [PORTS];
  logic [PORTS-1:0]     rx_valid;
  logic [PORTS-1:0]     rx_ready;
  sched_pkg::rx_word_t  core_out [PORTS];
  sched_pkg::desc_t     out_desc [PORTS];
  sched_pkg::port_id_t  out_port [PORTS];
  logic [PORTS-1:0]     out_valid;
  logic [PORTS-1:0]     out_ready;
  sched_pkg::ctrl_msg_t ctrl_in;
  sched_pkg::core_id_t  ctrl_src;
  logic                 ctrl_valid;
  logic                 ctrl_ready;
  sched_pkg::host_cmd_t host_cmd;
  logic [31:0]          host_rd_data;

  // Pool model, expected words and descriptors in flight
  sched_pkg::slot_id_t  pool_q [CORES][$];
  sched_pkg::rx_word_t  exp_q [PORTS][$];
  sched_pkg::desc_t     issued [$];
  sched_pkg::desc_t     held [PORTS];
  logic [PORTS-1:0]     held_valid;
  logic                 in_use [CORES][16];
  logic [PORTS-1:0]     in_pkt;
  logic [CORES-1:0]     elig;
  logic                 rand_ready;
  logic [31:0]          lfsr_state = 32'h54a1;
  int                   errors;
  int                   checks;
  int                   test_idx;
  int                   failed_tests;
  int                   test_err0;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) clock_i (.clk(clk), .rst_r(rst_r));

  rx_scheduler #(
    .CORE_COUNT(CORES),
    .SLOT_COUNT(SLOTS),
    .PORT_COUNT(PORTS)
  ) dut_i (
    .clk(clk), .rst_r(rst_r),
    .rx(rx), .rx_valid(rx_valid), .rx_ready(rx_ready),
    .core_out(core_out), .out_desc(out_desc), .out_port(out_port),
    .out_valid(out_valid), .out_ready(out_ready),
    .ctrl_in(ctrl_in), .ctrl_src(ctrl_src), .ctrl_valid(ctrl_valid), .ctrl_ready(ctrl_ready),
    .host_cmd(host_cmd), .host_rd_data(host_rd_data)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Eligible core with the most free slots, lowest index on a tie
  function automatic int ref_core(input logic [CORES-1:0] mask);
    int best;
    int best_n;
    best = -1;
    best_n = 0;
    for (int c = 0; c < CORES; c++) begin
      if (mask[c] && pool_q[c].size() > best_n) begin
        best = c;
        best_n = pool_q[c].size();
      end
    end
    return best;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("[FAIL] %0d ns %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    test_idx++;
    if (errors != test_err0) failed_tests++;
    $display("test %0d %s: %s", test_idx, name, (errors == test_err0) ? "ok" : "errors");
    test_err0 = errors;
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    host_cmd = '{valid: 1'b1, write: 1'b1, addr: addr, wr_data: data};
    @(negedge clk);
    host_cmd.valid = 1'b0;
  endtask

  // Read data lands on the second clock after the command is driven
  task automatic check_read(input logic [2:0] addr, input int sel, input logic [31:0] exp,
                            input string name);
    @(negedge clk);
    host_cmd = '{valid: 1'b1, write: 1'b0, addr: addr, wr_data: 32'(sel)};
    @(negedge clk);
    host_cmd.valid = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_val(name, host_rd_data, exp);
  endtask

  task automatic send_ctrl(input int core, input sched_pkg::msg_type_e kind, input int slot);
    @(negedge clk);
    ctrl_in = '0;
    ctrl_in.msg_type = kind;
    ctrl_in.slot = sched_pkg::slot_id_t'(slot);
    ctrl_src = sched_pkg::core_id_t'(core);
    ctrl_valid = 1'b1;
    @(posedge clk);
    while (!ctrl_ready) @(posedge clk);
    @(negedge clk);
    ctrl_valid = 1'b0;
  endtask

  task automatic send_packet(input int p, input int len);
    sched_pkg::rx_word_t w;
    for (int i = 0; i < len; i++) begin
      w.data = {rand_bits(32), rand_bits(32)};
      w.keep = (i == len - 1) ? (8'(rand_bits(8)) | 8'h01) : 8'hFF;
      w.last = (i == len - 1);
      exp_q[p].push_back(w);
      @(negedge clk);
      rx[p] = w;
      rx_valid[p] = 1'b1;
      @(posedge clk);
      while (!rx_ready[p]) @(posedge clk);
    end
    @(negedge clk);
    rx_valid[p] = 1'b0;
  endtask

  // The model hands out the slot that the DUT grants next on this port
  task automatic predict_grant(input int p);
    int c;
    c = ref_core(elig);
    held_valid[p] = (c >= 0);
    if (c >= 0) begin
      held[p].core = sched_pkg::core_id_t'(c);
      held[p].slot = pool_q[c].pop_front();
    end
  endtask

  task automatic check_desc(input int p, input sched_pkg::desc_t d);
    int idx;
    idx = -1;
    if (held_valid[p]) begin
      check_val($sformatf("out_desc[%0d].core", p), d.core, held[p].core);
      check_val($sformatf("out_desc[%0d].slot", p), d.slot, held[p].slot);
      held_valid[p] = 1'b0;
    end else begin
      // Grants can surface out of order across ports
      // Each port holds at most one unseen grant
      for (int i = 0; i < pool_q[d.core].size(); i++) begin
        if (idx < 0 && pool_q[d.core][i] == d.slot) idx = i;
      end
      expect_true(elig[d.core] && idx >= 0 && idx < PORTS,
                  $sformatf("port %0d got core %0d slot %0d, %s", p, d.core, d.slot,
                            "which is not a head of an eligible core queue"));
      if (idx >= 0) pool_q[d.core].delete(idx);
    end
    expect_true(!in_use[d.core][d.slot],
                $sformatf("core %0d slot %0d issued again before its return", d.core, d.slot));
    in_use[d.core][d.slot] = 1'b1;
    issued.push_back(d);
  endtask

  task automatic check_beat(input int p);
    sched_pkg::rx_word_t exp_w;
    expect_true(exp_q[p].size() != 0, $sformatf("port %0d put out a word never driven", p));
    if (exp_q[p].size() == 0) return;
    exp_w = exp_q[p].pop_front();
    check_val($sformatf("core_out[%0d].data", p), core_out[p].data, exp_w.data);
    check_val($sformatf("core_out[%0d].keep", p), core_out[p].keep, exp_w.keep);
    check_val($sformatf("core_out[%0d].last", p), core_out[p].last, exp_w.last);
    check_val($sformatf("out_port[%0d]", p), out_port[p], p);
    if (!in_pkt[p]) check_desc(p, out_desc[p]);
    in_pkt[p] = !exp_w.last;
  endtask

  always @(posedge clk) begin
    if (!rst_r) begin
      for (int p = 0; p < PORTS; p++) begin
        if (out_valid[p] && out_ready[p]) check_beat(p);
      end
    end
  end

  initial begin
    out_ready = '1;
    forever begin
      @(negedge clk);
      for (int p = 0; p < PORTS; p++) begin
        out_ready[p] = rand_ready ? (rand_bits(2) != 0) : 1'b1;
      end
    end
  end

  initial begin
    #(NUM_TESTS * MAX_LEN * PERIOD_NS * MARGIN);
    $display("Watchdog expired at %0d ns before the tests finished", $time);
    $display("sim failed");
    $finish;
  end

  initial begin
    sched_pkg::desc_t d;
    int cnt;
    int c_full;
    int c_off;
    for (int p = 0; p < PORTS; p++) rx[p] = '0;
    rx_valid = '0;
    ctrl_in = '0;
    ctrl_src = '0;
    ctrl_valid = 1'b0;
    host_cmd = '0;
    held_valid = '0;
    in_pkt = '0;
    elig = '0;
    rand_ready = 1'b0;
    errors = 0;
    checks = 0;
    test_idx = 0;
    failed_tests = 0;
    test_err0 = 0;
    for (int c = 0; c < CORES; c++) begin
      for (int s = 0; s < 16; s++) in_use[c][s] = 1'b0;
    end
    wait (!rst_r);
    @(negedge clk);

    check_val("host_rd_data", host_rd_data, 0);
    check_val("ctrl_ready", ctrl_ready, 1);
    check_read(3'd0, 0, 0, "incoming mask");
    check_read(3'd1, 0, 0, "enabled mask");
    check_read(3'd3, 0, 0, "overflow flag");
    check_read(3'd5, 0, 0, "port mask");
    check_val("rx_ready", rx_ready, 0);
    check_val("out_valid", out_valid, 0);
    finish_test("reset state");

    host_write(3'd1, 32'hB);
    host_write(3'd0, 32'h6);
    check_read(3'd1, 0, 32'hB, "enabled mask");
    check_read(3'd0, 0, 32'h6 & 32'hB, "incoming mask");
    host_write(3'd5, 32'h2);
    check_read(3'd5, 0, 32'h2, "port mask");
    host_write(3'd1, 32'h9);
    check_read(3'd0, 0, 32'h2 & 32'h9, "incoming mask");
    check_read(3'd6, 0, 32'hFEFEFEFE, "unused address");
    host_write(3'd5, 32'h0);
    finish_test("host masks");

    for (int c = 0; c < CORES; c++) begin
      cnt = 1 + int'(rand_bits(3));
      send_ctrl(c, sched_pkg::SLOT_INIT, cnt);
      pool_q[c].delete();
      for (int s = 1; s <= cnt; s++) pool_q[c].push_back(sched_pkg::slot_id_t'(s));
    end
    repeat (SLOTS + 4) @(negedge clk);
    for (int c = 0; c < CORES; c++) begin
      check_read(3'd2, c, pool_q[c].size(), $sformatf("free count core %0d", c));
    end
    finish_test("slot init and counts");

    host_write(3'd1, 32'hF);
    host_write(3'd0, 32'hF);
    elig = '1;
    host_write(3'd5, 32'h1);
    predict_grant(0);
    for (int k = 0; k < 6 && held_valid[0]; k++) begin
      send_packet(0, 1 + int'(rand_bits(3)));
      predict_grant(0);
    end
    finish_test("destination choice");

    host_write(3'd5, 32'h0);
    while (issued.size() > 0) begin
      d = issued.pop_front();
      send_ctrl(d.core, sched_pkg::SLOT_RETURN, d.slot);
      pool_q[d.core].push_back(d.slot);
      in_use[d.core][d.slot] = 1'b0;
    end
    repeat (4) @(negedge clk);
    for (int c = 0; c < CORES; c++) begin
      check_read(3'd2, c, pool_q[c].size(), $sformatf("free count core %0d", c));
    end
    // Fill a core that holds no slot still in flight
    c_full = held_valid[0] ? (int'(held[0].core) + 1) % CORES : 0;
    send_ctrl(c_full, sched_pkg::SLOT_INIT, SLOTS);
    pool_q[c_full].delete();
    for (int s = 1; s <= SLOTS; s++) pool_q[c_full].push_back(sched_pkg::slot_id_t'(s));
    repeat (SLOTS + 4) @(negedge clk);
    check_read(3'd2, c_full, SLOTS, "free count of full core");
    check_read(3'd3, 0, 0, "overflow flag");
    send_ctrl(c_full, sched_pkg::SLOT_RETURN, SLOTS);
    repeat (4) @(negedge clk);
    check_read(3'd3, 0, 1, "overflow flag");
    check_read(3'd2, c_full, pool_q[c_full].size(), "free count after overflow");
    host_write(3'd3, 32'h0);
    check_read(3'd3, 0, 0, "overflow flag");
    finish_test("slot return and overflow");

    rand_ready = 1'b1;
    // One core leaves the incoming set, the full core stays in
    c_off = (c_full + 1) % CORES;
    host_write(3'd0, 32'hF & ~(32'h1 << c_off));
    elig[c_off] = 1'b0;
    host_write(3'd5, 32'h3);
    fork
      for (int k = 0; k < 4; k++) send_packet(0, 1 + int'(rand_bits(3)));
      for (int k = 0; k < 4; k++) send_packet(1, 1 + int'(rand_bits(3)));
    join
    rand_ready = 1'b0;
    repeat (2) @(negedge clk);
    for (int p = 0; p < PORTS; p++) begin
      expect_true(exp_q[p].size() == 0, $sformatf("port %0d left words undelivered", p));
    end
    finish_test("two ports under back-pressure");

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             test_idx, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/sched_pkg.sv
rtl/ctrl_msg_decoder.sv
rtl/slot_pool.sv
rtl/core_selector.sv
rtl/port_dispatcher.sv
rtl/host_regs.sv
rtl/rx_scheduler.sv
sim/tb_clock_gen.sv
sim/rx_scheduler_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rx_scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module rx_scheduler_tb -f src.f -o rx_scheduler_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/rx_scheduler_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
